// File: rtl/rv_config_pkg.sv
`default_nettype none

package rv_config_pkg;

    localparam int DATA_WIDTH = 32;    // Instruction and data word
    localparam int REG_WIDTH  = 5;     // GPR address
    localparam int CSR_WIDTH  = 12;    // CSR address

    // Multiply and divide instructions decode as ALU ops when set
    localparam bit RV_EXT_M   = 1'b1;

endpackage

`default_nettype wire

// File: rtl/rv_types_pkg.sv
`default_nettype none

package rv_types_pkg;

    import rv_config_pkg::*;

    typedef logic [DATA_WIDTH-1:0] inst_t;      // Raw instruction word
    typedef logic [DATA_WIDTH-1:0] data_t;      // Immediate or data value
    typedef logic [REG_WIDTH-1:0]  gpr_addr_t;  // x0..x31
    typedef logic [CSR_WIDTH-1:0]  csr_addr_t;  // CSR number

    // Major opcodes in bits [6:0]
    typedef enum logic [6:0] {
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_FENCE  = 7'b0001111,
        OPCODE_SYSTEM = 7'b1110011
    } opcode_t;

    typedef logic [3:0] trap_cause_t;           // Low bits of mcause

    localparam trap_cause_t CAUSE_ILLEGAL    = 4'd2;   // Illegal instruction
    localparam trap_cause_t CAUSE_BREAKPOINT = 4'd3;   // EBREAK
    localparam trap_cause_t CAUSE_ECALL_M    = 4'd11;  // ECALL from M-mode

endpackage

`default_nettype wire

// File: rtl/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

    import rv_types_pkg::*;

    logic      valid;       // Fields below meaningful only when set
    opcode_t   op;
    gpr_addr_t rs1;
    gpr_addr_t rs2;
    gpr_addr_t rd;
    csr_addr_t csr;
    data_t     imm;         // Immediate for the word's format
    logic      is_alu;
    logic      is_csr;
    logic      is_wfi;
    logic      is_mret;
    logic      is_illegal;  // Exception flags
    logic      is_ecall;
    logic      is_ebreak;

    modport producer (output valid, op, rs1, rs2, rd, csr, imm,
                      output is_alu, is_csr, is_wfi, is_mret,
                      output is_illegal, is_ecall, is_ebreak);

    modport consumer (input valid, op, rs1, rs2, rd, csr, imm,
                      input is_alu, is_csr, is_wfi, is_mret,
                      input is_illegal, is_ecall, is_ebreak);

endinterface

`default_nettype wire

// File: rtl/inst_fetch_latch.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fetch_latch (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_inst_valid,  // New word this cycle
    input  rv_types_pkg::inst_t i_inst,
    output logic                o_valid,       // Registered strobe
    output rv_types_pkg::inst_t o_inst         // Held word for the decoder
);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid <= 1'b0;
            o_inst  <= '0;
        end
        else
        begin
            o_valid <= i_inst_valid;
            if (i_inst_valid)
                o_inst <= i_inst;  // Word stays put while idle
        end
    end

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic                i_valid,  // From fetch latch
    input  rv_types_pkg::inst_t i_inst,   // Word to decode
    decode_if.producer          dec
);

    import rv_config_pkg::*;
    import rv_types_pkg::*;

    data_t imm_i;
    data_t imm_s;
    data_t imm_b;
    data_t imm_u;
    data_t imm_j;
    data_t imm_shamt;
    data_t imm_csr;

    assign imm_i     = {{21{i_inst[31]}}, i_inst[30:20]};
    assign imm_s     = {{21{i_inst[31]}}, i_inst[30:25], i_inst[11:7]};
    assign imm_b     = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u     = {i_inst[31:12], 12'b0};
    assign imm_j     = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
    assign imm_shamt = {{(DATA_WIDTH-REG_WIDTH){1'b0}}, i_inst[24:20]};
    assign imm_csr   = {{(DATA_WIDTH-REG_WIDTH){1'b0}}, i_inst[19:15]};  // uimm in rs1 slot

    always_comb
    begin
        dec.valid      = i_valid;
        dec.op         = opcode_t'(i_inst[6:0]);
        dec.rs1        = i_inst[REG_WIDTH+14:15];
        dec.rs2        = i_inst[REG_WIDTH+19:20];
        dec.rd         = i_inst[REG_WIDTH+6:7];
        dec.csr        = i_inst[CSR_WIDTH+19:20];
        dec.imm        = '0;

        dec.is_alu     = 1'b0;
        dec.is_csr     = 1'b0;
        dec.is_wfi     = 1'b0;
        dec.is_mret    = 1'b0;
        dec.is_illegal = 1'b0;
        dec.is_ecall   = 1'b0;
        dec.is_ebreak  = 1'b0;

        // Key is funct7, funct3, opcode
        unique casez ({i_inst[31:25], i_inst[14:12], i_inst[6:0]})
            {10'b???????_???, OPCODE_LUI},
            {10'b???????_???, OPCODE_AUIPC}:
                dec.imm = imm_u;

            {10'b???????_???, OPCODE_JAL}:
                dec.imm = imm_j;

            {10'b???????_000, OPCODE_JALR}:
                dec.imm = imm_i;

            {10'b???????_000, OPCODE_BRANCH},  // BEQ
            {10'b???????_001, OPCODE_BRANCH},  // BNE
            {10'b???????_100, OPCODE_BRANCH},  // BLT
            {10'b???????_101, OPCODE_BRANCH},  // BGE
            {10'b???????_110, OPCODE_BRANCH},  // BLTU
            {10'b???????_111, OPCODE_BRANCH}:  // BGEU
                dec.imm = imm_b;

            {10'b???????_000, OPCODE_LOAD},    // LB
            {10'b???????_001, OPCODE_LOAD},    // LH
            {10'b???????_010, OPCODE_LOAD},    // LW
            {10'b???????_100, OPCODE_LOAD},    // LBU
            {10'b???????_101, OPCODE_LOAD}:    // LHU
                dec.imm = imm_i;

            {10'b???????_000, OPCODE_STORE},   // SB
            {10'b???????_001, OPCODE_STORE},   // SH
            {10'b???????_010, OPCODE_STORE}:   // SW
                dec.imm = imm_s;

            {10'b???????_000, OPCODE_OP_IMM},  // ADDI
            {10'b???????_010, OPCODE_OP_IMM},  // SLTI
            {10'b???????_011, OPCODE_OP_IMM},  // SLTIU
            {10'b???????_100, OPCODE_OP_IMM},  // XORI
            {10'b???????_110, OPCODE_OP_IMM},  // ORI
            {10'b???????_111, OPCODE_OP_IMM}:  // ANDI
            begin
                dec.imm    = imm_i;
                dec.is_alu = 1'b1;
            end

            {10'b0000000_001, OPCODE_OP_IMM},  // SLLI
            {10'b0000000_101, OPCODE_OP_IMM},  // SRLI
            {10'b0100000_101, OPCODE_OP_IMM}:  // SRAI
            begin
                dec.imm    = imm_shamt;
                dec.is_alu = 1'b1;
            end

            {10'b0000000_000, OPCODE_OP},      // ADD
            {10'b0100000_000, OPCODE_OP},      // SUB
            {10'b0000000_001, OPCODE_OP},      // SLL
            {10'b0000000_010, OPCODE_OP},      // SLT
            {10'b0000000_011, OPCODE_OP},      // SLTU
            {10'b0000000_100, OPCODE_OP},      // XOR
            {10'b0000000_101, OPCODE_OP},      // SRL
            {10'b0100000_101, OPCODE_OP},      // SRA
            {10'b0000000_110, OPCODE_OP},      // OR
            {10'b0000000_111, OPCODE_OP}:      // AND
                dec.is_alu = 1'b1;

            {10'b0000001_???, OPCODE_OP}:      // MUL/DIV/REM group
            begin
                if (RV_EXT_M)
                    dec.is_alu = 1'b1;
                else
                    dec.is_illegal = 1'b1;
            end

            // No memory ordering support in this core
            {10'b0000???_000, OPCODE_FENCE},   // FENCE
            {10'b0000000_001, OPCODE_FENCE}:   // FENCE.I
                dec.is_illegal = 1'b1;

            {10'b0000000_000, OPCODE_SYSTEM}:
            begin
                case ({i_inst[24:20], i_inst[19:15], i_inst[11:7]})
                    15'b00000_00000_00000: dec.is_ecall  = 1'b1;
                    15'b00001_00000_00000: dec.is_ebreak = 1'b1;
                    default:               dec.is_illegal = 1'b1;
                endcase
            end

            {10'b0001000_000, OPCODE_SYSTEM}:
            begin
                if ({i_inst[24:20], i_inst[19:15], i_inst[11:7]} == 15'b00101_00000_00000)
                    dec.is_wfi = 1'b1;
                else
                    dec.is_illegal = 1'b1;
            end

            {10'b0011000_000, OPCODE_SYSTEM}:
            begin
                if (i_inst[24:20] == 5'b00010)  // Only rs2 slot is checked
                    dec.is_mret = 1'b1;
                else
                    dec.is_illegal = 1'b1;
            end

            {10'b???????_001, OPCODE_SYSTEM},  // CSRRW
            {10'b???????_010, OPCODE_SYSTEM},  // CSRRS
            {10'b???????_011, OPCODE_SYSTEM}:  // CSRRC
                dec.is_csr = 1'b1;

            {10'b???????_101, OPCODE_SYSTEM},  // CSRRWI
            {10'b???????_110, OPCODE_SYSTEM},  // CSRRSI
            {10'b???????_111, OPCODE_SYSTEM}:  // CSRRCI
            begin
                dec.imm    = imm_csr;
                dec.is_csr = 1'b1;
            end

            default:
                dec.is_illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/decode_result_reg.sv
`timescale 1ns/1ps
`default_nettype none

module decode_result_reg (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    decode_if.consumer                dec,
    output logic                      o_valid,
    output rv_types_pkg::opcode_t     o_op,
    output rv_types_pkg::gpr_addr_t   o_rs1,
    output rv_types_pkg::gpr_addr_t   o_rs2,
    output rv_types_pkg::gpr_addr_t   o_rd,
    output rv_types_pkg::csr_addr_t   o_csr,
    output rv_types_pkg::data_t       o_imm,
    output logic                      o_is_alu,
    output logic                      o_is_csr,
    output logic                      o_is_wfi,
    output logic                      o_is_mret,
    output logic                      o_trap,        // Exception strobe
    output rv_types_pkg::trap_cause_t o_trap_cause   // mcause code, zero if none
);

    import rv_types_pkg::*;

    logic        trap;
    trap_cause_t cause;

    always_comb
    begin
        trap = dec.valid & (dec.is_illegal | dec.is_ecall | dec.is_ebreak);
        if (!trap)
            cause = '0;
        else if (dec.is_illegal)
            cause = CAUSE_ILLEGAL;
        else if (dec.is_ebreak)
            cause = CAUSE_BREAKPOINT;
        else
            cause = CAUSE_ECALL_M;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid      <= 1'b0;
            o_op         <= opcode_t'('0);
            o_rs1        <= '0;
            o_rs2        <= '0;
            o_rd         <= '0;
            o_csr        <= '0;
            o_imm        <= '0;
            o_is_alu     <= 1'b0;
            o_is_csr     <= 1'b0;
            o_is_wfi     <= 1'b0;
            o_is_mret    <= 1'b0;
            o_trap       <= 1'b0;
            o_trap_cause <= '0;
        end
        else
        begin
            o_valid      <= dec.valid;
            o_trap       <= trap;
            o_trap_cause <= cause;
            if (dec.valid)
            begin
                o_op      <= dec.op;
                o_rs1     <= dec.rs1;
                o_rs2     <= dec.rs2;
                o_rd      <= dec.rd;
                o_csr     <= dec.csr;
                o_imm     <= dec.imm;
                o_is_alu  <= dec.is_alu  & ~trap;  // Trapping word has no class
                o_is_csr  <= dec.is_csr  & ~trap;
                o_is_wfi  <= dec.is_wfi  & ~trap;
                o_is_mret <= dec.is_mret & ~trap;
            end
            else
            begin
                o_op      <= opcode_t'('0);  // Idle cycle reads all zero
                o_rs1     <= '0;
                o_rs2     <= '0;
                o_rd      <= '0;
                o_csr     <= '0;
                o_imm     <= '0;
                o_is_alu  <= 1'b0;
                o_is_csr  <= 1'b0;
                o_is_wfi  <= 1'b0;
                o_is_mret <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_stage (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_inst_valid,  // One word per high cycle
    input  rv_types_pkg::inst_t       i_inst,
    output logic                      o_valid,       // Two cycles after input
    output rv_types_pkg::opcode_t     o_op,
    output rv_types_pkg::gpr_addr_t   o_rs1,
    output rv_types_pkg::gpr_addr_t   o_rs2,
    output rv_types_pkg::gpr_addr_t   o_rd,
    output rv_types_pkg::csr_addr_t   o_csr,
    output rv_types_pkg::data_t       o_imm,
    output logic                      o_is_alu,
    output logic                      o_is_csr,
    output logic                      o_is_wfi,
    output logic                      o_is_mret,
    output logic                      o_trap,
    output rv_types_pkg::trap_cause_t o_trap_cause
);

    import rv_types_pkg::*;

    logic  fetch_valid;
    inst_t fetch_inst;

    decode_if dec_bus ();  // Decoder to result register

    inst_fetch_latch fetch_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .o_valid      (fetch_valid),
        .o_inst       (fetch_inst)
    );

    inst_decoder decoder_i (
        .i_valid (fetch_valid),
        .i_inst  (fetch_inst),
        .dec     (dec_bus)
    );

    decode_result_reg result_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .dec          (dec_bus),
        .o_valid      (o_valid),
        .o_op         (o_op),
        .o_rs1        (o_rs1),
        .o_rs2        (o_rs2),
        .o_rd         (o_rd),
        .o_csr        (o_csr),
        .o_imm        (o_imm),
        .o_is_alu     (o_is_alu),
        .o_is_csr     (o_is_csr),
        .o_is_wfi     (o_is_wfi),
        .o_is_mret    (o_is_mret),
        .o_trap       (o_trap),
        .o_trap_cause (o_trap_cause)
    );

endmodule

`default_nettype wire

// File: tb/rv_decode_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_properties (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_inst_valid,
    input logic i_valid,    // Stage output strobe
    input logic i_trap,
    input logic i_is_alu,
    input logic i_is_csr,
    input logic i_is_wfi,
    input logic i_is_mret
);

    int fail_count = 0;

    a_trap_needs_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_trap |-> i_valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("o_trap high while o_valid is low");
    end

    a_trap_no_class: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_trap |-> !(i_is_alu || i_is_csr || i_is_wfi || i_is_mret))
    else
    begin
        fail_count = fail_count + 1;
        $error("Class flag set on a trapping word");
    end

    // Fixed two-cycle latency, both directions
    a_valid_follows: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_inst_valid |-> ##2 i_valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("o_valid missing two cycles after a strobed word");
    end

    a_idle_follows: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_inst_valid |-> ##2 !i_valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("o_valid high two cycles after an idle cycle");
    end

endmodule

bind rv_decode_stage rv_decode_properties props_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_valid      (o_valid),
    .i_trap       (o_trap),
    .i_is_alu     (o_is_alu),
    .i_is_csr     (o_is_csr),
    .i_is_wfi     (o_is_wfi),
    .i_is_mret    (o_is_mret)
);

`default_nettype wire

// File: tb/tb_rv_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode_stage;

    import rv_config_pkg::*;
    import rv_types_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 2;
    localparam int NUM_CYCLES      = 3000;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CYCLES + 2 + 100;

    typedef struct packed {
        logic        valid;
        logic [6:0]  op;
        gpr_addr_t   rs1;
        gpr_addr_t   rs2;
        gpr_addr_t   rd;
        csr_addr_t   csr;
        data_t       imm;
        logic        is_alu;
        logic        is_csr;
        logic        is_wfi;
        logic        is_mret;
        logic        trap;
        trap_cause_t cause;
    } expect_t;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_inst_valid;
    inst_t       i_inst;
    logic        o_valid;
    opcode_t     o_op;
    gpr_addr_t   o_rs1;
    gpr_addr_t   o_rs2;
    gpr_addr_t   o_rd;
    csr_addr_t   o_csr;
    data_t       o_imm;
    logic        o_is_alu;
    logic        o_is_csr;
    logic        o_is_wfi;
    logic        o_is_mret;
    logic        o_trap;
    trap_cause_t o_trap_cause;

    logic [31:0] rng_state;
    logic [31:0] coin;
    logic        stim_valid;
    inst_t       stim_word;
    expect_t     dl0;  // Word driven this edge
    expect_t     dl1;
    expect_t     dl2;  // Word now on the outputs
    int          cyc;

    rv_decode_stage dut_i (.*);

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [6:0] opcode_by_index(input logic [3:0] idx);
        case (idx)
            4'd0:    return OPCODE_LUI;
            4'd1:    return OPCODE_AUIPC;
            4'd2:    return OPCODE_JAL;
            4'd3:    return OPCODE_JALR;
            4'd4:    return OPCODE_BRANCH;
            4'd5:    return OPCODE_LOAD;
            4'd6:    return OPCODE_STORE;
            4'd7:    return OPCODE_OP_IMM;
            4'd8:    return OPCODE_OP;
            4'd9:    return OPCODE_FENCE;
            default: return OPCODE_SYSTEM;
        endcase
    endfunction

    function automatic inst_t make_word();
        logic [31:0] r;
        logic [31:0] sel;
        inst_t       w;
        r   = next_rand();
        sel = next_rand();
        w   = next_rand();
        case (sel[3:0])
            4'd11: w[6:0] = r[6:0];                                // Any 7-bit opcode
            4'd12: w = 32'h0000_0073;                              // ECALL
            4'd13: w = 32'h0010_0073;                              // EBREAK
            4'd14: w = sel[4] ? 32'h1050_0073 : 32'h3020_0073;     // WFI or MRET
            4'd15: w = {r[31:20], w[19:15], 3'b000, w[11:7], 7'h73};  // Mostly malformed
            default:
            begin
                w[6:0] = opcode_by_index(sel[3:0]);
                case (r[9:8])                                      // Bias funct7 to legal
                    2'd0:    w[31:25] = 7'h00;
                    2'd1:    w[31:25] = 7'h20;
                    2'd2:    w[31:25] = 7'h01;
                    default: w[31:25] = w[31:25];
                endcase
            end
        endcase
        return w;
    endfunction

    function automatic expect_t ref_decode(input logic v, input inst_t w);
        expect_t    e;
        logic [6:0] f7;
        logic [2:0] f3;
        logic       no_regs;
        logic       ill;
        logic       ecall;
        logic       ebreak;
        e       = '0;
        f7      = w[31:25];
        f3      = w[14:12];
        no_regs = (w[19:15] == 5'd0) && (w[11:7] == 5'd0);
        ill     = 1'b0;
        ecall   = 1'b0;
        ebreak  = 1'b0;
        if (!v)
            return e;  // Idle cycle reads all zero
        e.valid = 1'b1;
        e.op    = w[6:0];
        e.rs1   = w[19:15];
        e.rs2   = w[24:20];
        e.rd    = w[11:7];
        e.csr   = w[31:20];
        case (w[6:0])
            OPCODE_LUI, OPCODE_AUIPC:
                e.imm = {w[31:12], 12'h000};
            OPCODE_JAL:
                e.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            OPCODE_JALR:
                if (f3 == 3'd0)
                    e.imm = 32'($signed(w[31:20]));
                else
                    ill = 1'b1;
            OPCODE_BRANCH:
                if (f3 != 3'd2 && f3 != 3'd3)
                    e.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
                else
                    ill = 1'b1;
            OPCODE_LOAD:
                if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5})
                    e.imm = 32'($signed(w[31:20]));
                else
                    ill = 1'b1;
            OPCODE_STORE:
                if (f3 <= 3'd2)
                    e.imm = 32'($signed({w[31:25], w[11:7]}));
                else
                    ill = 1'b1;
            OPCODE_OP_IMM:
            begin
                e.is_alu = 1'b1;
                if (f3 == 3'd1 || f3 == 3'd5)
                begin
                    e.imm = {27'd0, w[24:20]};  // Shift amount
                    if (!(f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)))
                        ill = 1'b1;
                end
                else
                    e.imm = 32'($signed(w[31:20]));
            end
            OPCODE_OP:
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))
                    || (f7 == 7'h01 && RV_EXT_M))
                    e.is_alu = 1'b1;
                else
                    ill = 1'b1;
            OPCODE_SYSTEM:
                if (f3 == 3'd0)
                begin
                    if (f7 == 7'h00 && w[24:20] == 5'd0 && no_regs)
                        ecall = 1'b1;
                    else if (f7 == 7'h00 && w[24:20] == 5'd1 && no_regs)
                        ebreak = 1'b1;
                    else if (f7 == 7'h08 && w[24:20] == 5'd5 && no_regs)
                        e.is_wfi = 1'b1;
                    else if (f7 == 7'h18 && w[24:20] == 5'd2)
                        e.is_mret = 1'b1;
                    else
                        ill = 1'b1;
                end
                else if (f3 == 3'd4)
                    ill = 1'b1;
                else
                begin
                    e.is_csr = 1'b1;
                    if (f3[2])
                        e.imm = {27'd0, w[19:15]};  // uimm form
                end
            default:
                ill = 1'b1;  // FENCE and unknown opcodes
        endcase
        if (ill || ecall || ebreak)
        begin
            e.imm     = '0;
            e.is_alu  = 1'b0;
            e.is_csr  = 1'b0;
            e.is_wfi  = 1'b0;
            e.is_mret = 1'b0;
            e.trap    = 1'b1;
            e.cause   = ill ? 4'd2 : (ebreak ? 4'd3 : 4'd11);
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAILED %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cyc);
            $display("Test failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        check_value("o_valid", 32'(o_valid), 32'(e.valid));
        check_value("o_op", 32'(o_op), 32'(e.op));
        check_value("o_rs1", 32'(o_rs1), 32'(e.rs1));
        check_value("o_rs2", 32'(o_rs2), 32'(e.rs2));
        check_value("o_rd", 32'(o_rd), 32'(e.rd));
        check_value("o_csr", 32'(o_csr), 32'(e.csr));
        check_value("o_imm", o_imm, e.imm);
        check_value("o_is_alu", 32'(o_is_alu), 32'(e.is_alu));
        check_value("o_is_csr", 32'(o_is_csr), 32'(e.is_csr));
        check_value("o_is_wfi", 32'(o_is_wfi), 32'(e.is_wfi));
        check_value("o_is_mret", 32'(o_is_mret), 32'(e.is_mret));
        check_value("o_trap", 32'(o_trap), 32'(e.trap));
        check_value("o_trap_cause", 32'(o_trap_cause), 32'(e.cause));
    endtask

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        i_rst_n      = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        rng_state    = 32'h943b_1050;
        dl0          = '0;
        dl1          = '0;
        dl2          = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;
        for (cyc = 0; cyc < NUM_CYCLES + 2; cyc++)
        begin
            @(posedge i_clk);
            coin       = next_rand();
            stim_valid = (cyc >= 3) && (cyc < NUM_CYCLES) && (coin[2:0] != 3'd0);
            stim_word  = make_word();  // Driven even in gaps
            dl2 = dl1;
            dl1 = dl0;
            dl0 = ref_decode(stim_valid, stim_word);
            i_inst_valid <= stim_valid;
            i_inst       <= stim_word;
            @(negedge i_clk);
            compare_outputs(dl2);
            assert (dut_i.props_i.fail_count == 0)
            else
            begin
                $display("Bound property check failed by cycle %0d", cyc);
                $display("Test failed");
                $fatal(1, "Property failure");
            end
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_decode.f
rtl/rv_config_pkg.sv
rtl/rv_types_pkg.sv
rtl/decode_if.sv
rtl/inst_fetch_latch.sv
rtl/inst_decoder.sv
rtl/decode_result_reg.sv
rtl/rv_decode_stage.sv
tb/rv_decode_properties.sv
tb/tb_rv_decode_stage.sv

// File: Makefile
TOP  := tb_rv_decode_stage
SRCS := $(wildcard rtl/*.sv tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): $(SRCS) rv_decode.f
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f rv_decode.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
